/* prefetchPkg.sv */
// prefetch queue shared definitions
// sizes, command and error encodings, and the bundles seen at the queue top
`default_nettype none

package prefetchPkg;

    localparam int LOG_QUEUE_SIZE = 4;                      // log2 of block count
    localparam int QUEUE_SIZE     = 1 << LOG_QUEUE_SIZE;    // 16 blocks
    localparam int BURST_LEN      = 4;                      // blocks per burst
    localparam int NUM_BURSTS     = QUEUE_SIZE / BURST_LEN; // burst slots
    localparam int LOG_NUM_BURSTS = 2;
    localparam int DATA_BITS      = 32;                     // block width
    localparam int ADDR_BITS      = 32;
    localparam int PROMISE_WIDTH  = 3;                      // promise counter width

    // command opcodes, 5..7 are refused as invalid
    typedef enum logic [2:0] {
        OP_NOP               = 3'd0,
        OP_READ_REQ_PREF     = 3'd1, // prefetcher asks for a burst, no promise
        OP_READ_REQ_MASTER   = 3'd2, // master AR, one promise
        OP_READ_DATA_SLAVE   = 3'd3, // DRAM R beat
        OP_READ_DATA_PROMISE = 3'd4  // master takes one block
    } opcodeT;

    typedef enum logic [2:0] {
        ERR_NONE           = 3'd0,
        ERR_INVALID_OPCODE = 3'd1,
        ERR_QUEUE_FULL     = 3'd2,
        ERR_NOT_READY      = 3'd3,
        ERR_DATA_OVERFLOW  = 3'd4
    } errorT;

    typedef struct packed {
        opcodeT                opcode; // command strobe, NOP when idle
        logic [ADDR_BITS-1:0]  addr;
        logic [DATA_BITS-1:0]  data;
        logic                  last;   // only on the final block of a burst
    } reqT;

    typedef struct packed {
        logic [DATA_BITS-1:0] data;
        logic                 last;
    } respT;

    typedef struct packed {
        logic                    addrHit;
        logic [LOG_NUM_BURSTS:0] prefetchReqCnt; // unpromised bursts queued
        logic                    almostFull;
        logic                    hasOutstanding; // some block still waits for DRAM
        logic                    respValid;
        errorT                   errorCode;      // registered, one cycle
    } statusT;

endpackage

`default_nettype wire

/* prefetchTagStore.sv */
// prefetch tag store
// one address tag, promise counter and prefetch flag per burst slot,
// with a priority address match and a count of pending prefetches
`timescale 1ns/1ps
`default_nettype none

module prefetchTagStore (
    input  logic                                  clk,
    input  logic                                  resetN,
    input  logic [prefetchPkg::ADDR_BITS-1:0]     addr,
    input  logic                                  allocTag,
    input  logic [prefetchPkg::LOG_NUM_BURSTS-1:0] allocSlot,
    input  logic                                  allocPromise,
    input  logic                                  promoteTag,
    input  logic [prefetchPkg::LOG_NUM_BURSTS-1:0] promoteSlot,
    input  logic                                  consumePromise,
    input  logic [prefetchPkg::LOG_NUM_BURSTS-1:0] consumeSlot,
    input  logic [prefetchPkg::NUM_BURSTS-1:0]    slotValid,
    input  logic [prefetchPkg::LOG_NUM_BURSTS-1:0] headSlot,
    output logic                                  hit,
    output logic [prefetchPkg::LOG_NUM_BURSTS-1:0] hitSlot,
    output logic [prefetchPkg::PROMISE_WIDTH-1:0] headPromiseCnt,
    output logic [prefetchPkg::PROMISE_WIDTH-1:0] nextPromiseCnt,
    output logic [prefetchPkg::LOG_NUM_BURSTS:0]  prefetchReqCnt
);

    typedef logic [prefetchPkg::LOG_NUM_BURSTS-1:0] slotT;

    logic [prefetchPkg::ADDR_BITS-1:0]     tagMem [prefetchPkg::NUM_BURSTS]; // burst start addr
    logic [prefetchPkg::PROMISE_WIDTH-1:0] promiseCnt [prefetchPkg::NUM_BURSTS];
    logic [prefetchPkg::NUM_BURSTS-1:0]    prefetchVec; // set while nobody has asked for it
    slotT                                  nextSlot;

    // tags only change on allocation
    always_ff @(posedge clk) begin
        if (allocTag) begin
            tagMem[allocSlot] <= addr;
        end
    end

    always_ff @(posedge clk or negedge resetN) begin
        if (!resetN) begin
            prefetchVec <= '0;
            for (int s = 0; s < prefetchPkg::NUM_BURSTS; s++) begin
                promiseCnt[s] <= '0;
            end
        end else begin
            for (int s = 0; s < prefetchPkg::NUM_BURSTS; s++) begin
                if (allocTag && allocSlot == slotT'(s)) begin
                    // fresh burst: master request brings one promise, prefetch none
                    promiseCnt[s] <= {{(prefetchPkg::PROMISE_WIDTH-1){1'b0}}, allocPromise};
                    prefetchVec[s] <= !allocPromise;
                end else begin
                    // promote and consume come from different opcodes, never together
                    if (promoteTag && promoteSlot == slotT'(s)) begin
                        promiseCnt[s]  <= promiseCnt[s] + 1'b1;
                        prefetchVec[s] <= 1'b0; // now wanted by the master
                    end
                    if (consumePromise && consumeSlot == slotT'(s)) begin
                        promiseCnt[s] <= promiseCnt[s] - 1'b1; // burst fully read once
                    end
                end
            end
        end
    end

    // address match, lowest slot wins
    always_comb begin
        hit     = 1'b0;
        hitSlot = '0;
        for (int s = 0; s < prefetchPkg::NUM_BURSTS; s++) begin
            if (!hit && slotValid[s] && tagMem[s] == addr) begin
                hit     = 1'b1;
                hitSlot = slotT'(s);
            end
        end
    end

    always_comb begin
        nextSlot       = headSlot + 1'b1; // wraps around the slot ring
        headPromiseCnt = promiseCnt[headSlot];
        nextPromiseCnt = promiseCnt[nextSlot];
        prefetchReqCnt = '0;
        for (int s = 0; s < prefetchPkg::NUM_BURSTS; s++) begin
            prefetchReqCnt = prefetchReqCnt + (slotValid[s] & prefetchVec[s]);
        end
    end

endmodule

`default_nettype wire

/* prefetchDataStore.sv */
// prefetch data store
// block data and last flags, filled in DRAM arrival order at readDataPtr,
// plus the per-block data-valid bits that feed readiness and pending status
`timescale 1ns/1ps
`default_nettype none

module prefetchDataStore (
    input  logic                                   clk,
    input  logic                                   resetN,
    input  logic [prefetchPkg::DATA_BITS-1:0]      fillData,
    input  logic                                   fillLast,
    input  logic                                   fillEn,
    input  logic [prefetchPkg::QUEUE_SIZE-1:0]     blockValid,
    input  logic [prefetchPkg::LOG_QUEUE_SIZE-1:0] headBlock,
    input  logic [prefetchPkg::LOG_QUEUE_SIZE-1:0] nextBlock,
    input  logic                                   clearBurst,
    input  logic [prefetchPkg::LOG_NUM_BURSTS-1:0] clearSlot,
    output logic                                   fillOk,
    output prefetchPkg::respT                      headData,
    output logic                                   headDataValid,
    output logic                                   nextDataValid,
    output logic                                   anyPending
);

    logic [prefetchPkg::DATA_BITS-1:0]      dataMem [prefetchPkg::QUEUE_SIZE];
    logic [prefetchPkg::QUEUE_SIZE-1:0]     lastVec;
    logic [prefetchPkg::QUEUE_SIZE-1:0]     dataValidVec; // block has its DRAM beat
    logic [prefetchPkg::LOG_QUEUE_SIZE-1:0] readDataPtr;  // next block to be filled

    // a fill needs an allocated block that is still empty
    assign fillOk = blockValid[readDataPtr] && !dataValidVec[readDataPtr];

    always_ff @(posedge clk) begin
        if (fillEn && fillOk) begin
            dataMem[readDataPtr] <= fillData;
            lastVec[readDataPtr] <= fillLast;
        end
    end

    always_ff @(posedge clk or negedge resetN) begin
        if (!resetN) begin
            dataValidVec <= '0;
            readDataPtr  <= '0;
        end else begin
            if (clearBurst) begin
                for (int b = 0; b < prefetchPkg::QUEUE_SIZE; b++) begin
                    if (b / prefetchPkg::BURST_LEN == clearSlot) begin
                        dataValidVec[b] <= 1'b0; // new burst starts empty
                    end
                end
            end
            if (fillEn && fillOk) begin
                dataValidVec[readDataPtr] <= 1'b1;
                readDataPtr               <= readDataPtr + 1'b1; // wraps with the ring
            end
        end
    end

    assign headData.data = dataMem[headBlock];
    assign headData.last = lastVec[headBlock];
    assign headDataValid = dataValidVec[headBlock];
    assign nextDataValid = dataValidVec[nextBlock]; // first block of the next burst

    // allocated but not yet filled
    assign anyPending = |(blockValid & ~dataValidVec);

endmodule

`default_nettype wire

/* prefetchQueueCtrl.sv */
// prefetch queue controller
// decodes the command strobe into store updates, keeps the burst ring
// (valid bits, head, tail, offset in head) and registers the error code
`timescale 1ns/1ps
`default_nettype none

module prefetchQueueCtrl (
    input  logic                                    clk,
    input  logic                                    resetN,
    input  prefetchPkg::reqT                        req,
    input  logic [prefetchPkg::LOG_NUM_BURSTS:0]    crsAlmostFullSpacer, // in bursts
    input  logic                                    hit,
    input  logic [prefetchPkg::LOG_NUM_BURSTS-1:0]  hitSlot,
    input  logic [prefetchPkg::PROMISE_WIDTH-1:0]   headPromiseCnt,
    input  logic [prefetchPkg::PROMISE_WIDTH-1:0]   nextPromiseCnt,
    input  prefetchPkg::respT                       headData,
    input  logic                                    headDataValid,
    input  logic                                    nextDataValid,
    input  logic                                    fillOk,
    output logic                                    allocTag,
    output logic [prefetchPkg::LOG_NUM_BURSTS-1:0]  allocSlot,
    output logic                                    allocPromise,
    output logic                                    promoteTag,
    output logic [prefetchPkg::LOG_NUM_BURSTS-1:0]  promoteSlot,
    output logic                                    consumePromise,
    output logic [prefetchPkg::LOG_NUM_BURSTS-1:0]  consumeSlot,
    output logic                                    fillEn,
    output logic [prefetchPkg::NUM_BURSTS-1:0]      slotValid,
    output logic [prefetchPkg::LOG_NUM_BURSTS-1:0]  headSlot,
    output logic [prefetchPkg::LOG_QUEUE_SIZE-1:0]  headBlock,
    output logic [prefetchPkg::LOG_QUEUE_SIZE-1:0]  nextBlock,
    output logic [prefetchPkg::QUEUE_SIZE-1:0]      blockValid,
    output logic                                    respValid,
    output logic                                    almostFull,
    output prefetchPkg::errorT                      errorCode
);

    typedef logic [prefetchPkg::LOG_NUM_BURSTS-1:0] slotT;
    typedef logic [prefetchPkg::LOG_QUEUE_SIZE-prefetchPkg::LOG_NUM_BURSTS-1:0] offsetT;

    logic [prefetchPkg::NUM_BURSTS-1:0] validVec;
    slotT                               tailSlot;
    slotT                               nextSlot;
    offsetT                             burstOffset;  // block inside the head burst
    logic [prefetchPkg::LOG_NUM_BURSTS:0]   validCnt;
    logic [prefetchPkg::LOG_NUM_BURSTS+1:0] fillLevel;  // valid bursts plus spacer
    logic                               full;
    logic                               headHasPromise;
    logic                               headReady;
    logic                               nextReady;
    logic                               serve;
    prefetchPkg::errorT                 errorNext;

    assign slotValid = validVec;

    always_comb begin
        nextSlot = headSlot + 1'b1;
        validCnt = '0;
        for (int s = 0; s < prefetchPkg::NUM_BURSTS; s++) begin
            validCnt = validCnt + validVec[s];
        end
        full       = &validVec; // no free slot left
        fillLevel  = validCnt + crsAlmostFullSpacer;
        almostFull = fillLevel >= prefetchPkg::NUM_BURSTS;
        for (int b = 0; b < prefetchPkg::QUEUE_SIZE; b++) begin
            blockValid[b] = validVec[b / prefetchPkg::BURST_LEN];
        end

        // head with promises serves its own block, otherwise look at the next burst
        headHasPromise = validVec[headSlot] && headPromiseCnt != '0;
        nextBlock      = {nextSlot, offsetT'(0)};
        headBlock      = headHasPromise ? {headSlot, burstOffset} : nextBlock;
        headReady      = headHasPromise && headDataValid;
        nextReady      = !headHasPromise && validVec[nextSlot] && nextDataValid
                         && nextPromiseCnt != '0;
        respValid      = headReady || nextReady;
        serve          = req.opcode == prefetchPkg::OP_READ_DATA_PROMISE && respValid;
    end

    // command decode, strobes are valid in the command cycle only
    always_comb begin
        allocTag       = 1'b0;
        allocPromise   = 1'b0;
        promoteTag     = 1'b0;
        fillEn         = 1'b0;
        errorNext      = prefetchPkg::ERR_NONE;
        allocSlot      = tailSlot;
        promoteSlot    = hitSlot;
        consumeSlot    = headHasPromise ? headSlot : nextSlot; // pop case serves next
        consumePromise = serve && headData.last;                // end of one burst read
        case (req.opcode)
            prefetchPkg::OP_NOP: errorNext = prefetchPkg::ERR_NONE;
            prefetchPkg::OP_READ_REQ_PREF: begin
                if (full) errorNext = prefetchPkg::ERR_QUEUE_FULL;
                else      allocTag  = 1'b1;
            end
            prefetchPkg::OP_READ_REQ_MASTER: begin
                if (hit) begin
                    promoteTag = 1'b1; // burst already queued, add a promise
                end else if (full) begin
                    errorNext = prefetchPkg::ERR_QUEUE_FULL;
                end else begin
                    allocTag     = 1'b1;
                    allocPromise = 1'b1;
                end
            end
            prefetchPkg::OP_READ_DATA_SLAVE: begin
                fillEn = 1'b1; // store drops it when no block is open
                if (!fillOk) errorNext = prefetchPkg::ERR_DATA_OVERFLOW;
            end
            prefetchPkg::OP_READ_DATA_PROMISE: begin
                if (!respValid) errorNext = prefetchPkg::ERR_NOT_READY;
            end
            default: errorNext = prefetchPkg::ERR_INVALID_OPCODE;
        endcase
    end

    always_ff @(posedge clk or negedge resetN) begin
        if (!resetN) begin
            validVec    <= '0;
            headSlot    <= '0;
            tailSlot    <= '0;
            burstOffset <= '0;
            errorCode   <= prefetchPkg::ERR_NONE;
        end else begin
            errorCode <= errorNext;
            if (allocTag) begin
                validVec[tailSlot] <= 1'b1;
                tailSlot           <= tailSlot + 1'b1;
            end
            if (serve) begin
                if (nextReady) begin // head used up, retire it
                    validVec[headSlot] <= 1'b0;
                    headSlot           <= nextSlot;
                end
                // step past the served block, back to 0 after last
                burstOffset <= headData.last ? offsetT'(0) : offsetT'(headBlock) + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* prefetchQueue.sv */
// prefetch data queue top
// tag store and data store side by side, steered by the queue controller
`timescale 1ns/1ps
`default_nettype none

module prefetchQueue (
    input  logic                                 clk,
    input  logic                                 resetN,
    input  prefetchPkg::reqT                     req,
    input  logic [prefetchPkg::LOG_NUM_BURSTS:0] crsAlmostFullSpacer,
    output prefetchPkg::respT                    resp,
    output prefetchPkg::statusT                  status
);

    logic                                   hit, allocTag, allocPromise, promoteTag;
    logic                                   consumePromise, fillEn, fillOk;
    logic                                   headDataValid, nextDataValid, anyPending;
    logic                                   respValid, almostFull;
    logic [prefetchPkg::LOG_NUM_BURSTS-1:0] hitSlot, allocSlot, promoteSlot;
    logic [prefetchPkg::LOG_NUM_BURSTS-1:0] consumeSlot, headSlot;
    logic [prefetchPkg::PROMISE_WIDTH-1:0]  headPromiseCnt, nextPromiseCnt;
    logic [prefetchPkg::LOG_NUM_BURSTS:0]   prefetchReqCnt;
    logic [prefetchPkg::NUM_BURSTS-1:0]     slotValid;
    logic [prefetchPkg::QUEUE_SIZE-1:0]     blockValid;
    logic [prefetchPkg::LOG_QUEUE_SIZE-1:0] headBlock, nextBlock;
    prefetchPkg::errorT                     errorCode;

    prefetchTagStore tagStore (
        .clk, .resetN, .addr(req.addr), .allocTag, .allocSlot, .allocPromise,
        .promoteTag, .promoteSlot, .consumePromise, .consumeSlot, .slotValid, .headSlot,
        .hit, .hitSlot, .headPromiseCnt, .nextPromiseCnt, .prefetchReqCnt
    );

    // a new burst clears its data-valid bits in the allocation cycle
    prefetchDataStore dataStore (
        .clk, .resetN, .fillData(req.data), .fillLast(req.last), .fillEn, .blockValid,
        .headBlock, .nextBlock, .clearBurst(allocTag), .clearSlot(allocSlot),
        .fillOk, .headData(resp), .headDataValid, .nextDataValid, .anyPending
    );

    prefetchQueueCtrl queueCtrl (
        .clk, .resetN, .req, .crsAlmostFullSpacer, .hit, .hitSlot, .headPromiseCnt,
        .nextPromiseCnt, .headData(resp), .headDataValid, .nextDataValid, .fillOk,
        .allocTag, .allocSlot, .allocPromise, .promoteTag, .promoteSlot, .consumePromise,
        .consumeSlot, .fillEn, .slotValid, .headSlot, .headBlock, .nextBlock, .blockValid,
        .respValid, .almostFull, .errorCode
    );

    assign status = '{addrHit: hit, prefetchReqCnt: prefetchReqCnt, almostFull: almostFull,
                      hasOutstanding: anyPending, respValid: respValid, errorCode: errorCode};

endmodule

`default_nettype wire

/* prefetchQueueSva.sv */
// prefetch queue assertions
// protocol checks on the queue top, bound into prefetchQueue
`timescale 1ns/1ps
`default_nettype none

module prefetchQueueSva (
    input logic                               clk,
    input logic                               resetN,
    input prefetchPkg::reqT                   req,
    input prefetchPkg::statusT                status,
    input logic [prefetchPkg::NUM_BURSTS-1:0] slotValid
);

    // an idle cycle leaves no error behind
    nopNoError: assert property (@(posedge clk) disable iff (!resetN)
        req.opcode == prefetchPkg::OP_NOP |=> status.errorCode == prefetchPkg::ERR_NONE)
        else $error("errorCode set after a NOP");

    // an empty queue has nothing to hand out, nothing pending and nothing to hit
    emptyQueueQuiet: assert property (@(posedge clk) disable iff (!resetN)
        slotValid == '0 |-> !status.respValid && !status.hasOutstanding
                            && !status.addrHit && status.prefetchReqCnt == '0)
        else $error("empty queue shows data, pending blocks or a hit");

    fullIsAlmostFull: assert property (@(posedge clk) disable iff (!resetN)
        &slotValid |-> status.almostFull)  // spacer can only move the mark earlier
        else $error("queue full but almostFull low");

endmodule

bind prefetchQueue prefetchQueueSva sva (
    .clk, .resetN, .req, .status, .slotValid
);

`default_nettype wire

/* prefetchQueueTb.sv */
// prefetch queue testbench
// directed scenarios plus a random command mix, checked every cycle against a model
`timescale 1ns/1ps
`default_nettype none

module prefetchQueueTb;

    localparam int CLK_PERIOD = 40;
    localparam int NUM_RANDOM = 400;
    localparam int NUM_CMDS   = 90 + NUM_RANDOM;
    localparam int NB         = prefetchPkg::NUM_BURSTS;
    localparam int QS         = prefetchPkg::QUEUE_SIZE;

    logic clk, resetN;
    prefetchPkg::reqT    req;
    logic [prefetchPkg::LOG_NUM_BURSTS:0] spacer;
    prefetchPkg::respT   resp;
    prefetchPkg::statusT status;
    prefetchPkg::respT   expResp;
    prefetchPkg::statusT expStatus;
    string testName;
    int    seed = 32'h9d09_4cf2;
    int    errSeen [8];

    // model state
    logic [NB-1:0] mValid, mPref;
    logic [1:0]    mHead, mTail, mOff;
    logic [31:0]   mTag [NB];
    logic [2:0]    mProm [NB];
    logic [QS-1:0] mDv, mLast;
    logic [31:0]   mData [QS];
    logic [3:0]    mPtr;                     // next block to fill
    prefetchPkg::errorT mErr;

    prefetchQueue UUT (.clk, .resetN, .req, .crsAlmostFullSpacer(spacer), .resp, .status);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD/2) clk = ~clk;
    end

    task automatic reportFailure(input string msg);
        $display("%s", msg);
        $display("*** FAILED ***");
        $fatal(1, "test stopped at the first error");
    endtask

    function automatic void resetModel();
        mValid = '0;
        mPref  = '0;
        mHead  = '0;
        mTail  = '0;
        mOff   = '0;
        mDv    = '0;
        mPtr   = '0;
        mErr   = prefetchPkg::ERR_NONE;
        for (int s = 0; s < NB; s++) mProm[s] = '0;
    endfunction

    function automatic void allocBurst(input logic [31:0] addr, input logic promise);
        mTag[mTail]  = addr;
        mProm[mTail] = {2'b00, promise};
        mPref[mTail] = !promise;             // unpromised means prefetch
        mValid[mTail] = 1'b1;
        for (int o = 0; o < 4; o++) mDv[{mTail, o[1:0]}] = 1'b0;
        mTail = mTail + 1'b1;
    endfunction

    // expected outputs for the current state and command followed by the next state
    function automatic void modelQueue(input prefetchPkg::reqT r, input logic [2:0] sp,
                                       output prefetchPkg::respT eResp,
                                       output prefetchPkg::statusT eStat);
        logic hit, headHas, hReady, nReady, rv, full, pending;
        logic [1:0] hitSlot, nextS, cSlot;
        logic [3:0] hb;
        int cnt, prefCnt;
        prefetchPkg::errorT errNext;
        hit     = 1'b0;
        hitSlot = '0;
        cnt     = 0;
        prefCnt = 0;
        pending = 1'b0;
        for (int s = 0; s < NB; s++) begin
            if (!hit && mValid[s] && mTag[s] == r.addr) begin
                hit = 1'b1;
                hitSlot = s[1:0];            // lowest matching burst
            end
            cnt += mValid[s];
            prefCnt += mValid[s] & mPref[s];
        end
        for (int b = 0; b < QS; b++) pending |= mValid[b/4] & !mDv[b];
        nextS   = mHead + 1'b1;
        full    = &mValid;
        headHas = mValid[mHead] && mProm[mHead] != 0;
        hb      = headHas ? {mHead, mOff} : {nextS, 2'b00};
        hReady  = headHas && mDv[hb];
        nReady  = !headHas && mValid[nextS] && mDv[{nextS, 2'b00}] && mProm[nextS] != 0;
        rv      = hReady || nReady;
        eResp.data = mData[hb];
        eResp.last = mLast[hb];
        eStat.addrHit        = hit;
        eStat.prefetchReqCnt = prefCnt[2:0];
        eStat.almostFull     = cnt + sp >= NB;
        eStat.hasOutstanding = pending;
        eStat.respValid      = rv;
        eStat.errorCode      = mErr;
        errNext = prefetchPkg::ERR_NONE;
        case (r.opcode)
            prefetchPkg::OP_NOP: errNext = prefetchPkg::ERR_NONE;
            prefetchPkg::OP_READ_REQ_PREF: begin
                if (full) errNext = prefetchPkg::ERR_QUEUE_FULL;
                else allocBurst(r.addr, 1'b0);
            end
            prefetchPkg::OP_READ_REQ_MASTER: begin
                if (hit) begin
                    mProm[hitSlot] = mProm[hitSlot] + 1'b1;
                    mPref[hitSlot] = 1'b0;
                end else if (full) errNext = prefetchPkg::ERR_QUEUE_FULL;
                else allocBurst(r.addr, 1'b1);
            end
            prefetchPkg::OP_READ_DATA_SLAVE: begin
                if (mValid[mPtr[3:2]] && !mDv[mPtr]) begin
                    mData[mPtr] = r.data;
                    mLast[mPtr] = r.last;
                    mDv[mPtr]   = 1'b1;
                    mPtr        = mPtr + 1'b1;
                end else errNext = prefetchPkg::ERR_DATA_OVERFLOW;
            end
            prefetchPkg::OP_READ_DATA_PROMISE: begin
                if (!rv) errNext = prefetchPkg::ERR_NOT_READY;
                else begin
                    if (mLast[hb]) begin     // one full pass of a burst uses a promise
                        cSlot = headHas ? mHead : nextS;
                        mProm[cSlot] = mProm[cSlot] - 1'b1;
                    end
                    mOff = mLast[hb] ? 2'b00 : hb[1:0] + 1'b1;
                    if (nReady) begin        // pop the spent head
                        mValid[mHead] = 1'b0;
                        mHead = nextS;
                    end
                end
            end
            default: errNext = prefetchPkg::ERR_INVALID_OPCODE;
        endcase
        errSeen[int'(errNext)]++;
        mErr = errNext;
    endfunction

    task automatic checkResp(input prefetchPkg::respT exp, input prefetchPkg::respT act);
        if (act !== exp) reportFailure($sformatf("CHECK FAILED %s resp expected %h actual %h",
                                                 testName, exp, act));
    endtask

    task automatic checkStatus(input prefetchPkg::statusT exp, input prefetchPkg::statusT act);
        if (act !== exp) reportFailure($sformatf("CHECK FAILED %s status expected %h actual %h",
                                                 testName, exp, act));
    endtask

    task automatic checkError(input prefetchPkg::errorT exp, input prefetchPkg::errorT act);
        if (act !== exp) reportFailure($sformatf("CHECK FAILED %s errorCode expected %s actual %s",
                                                 testName, exp.name(), act.name()));
    endtask

    // outputs are settled mid cycle
    initial begin
        resetModel();
        forever begin
            @(negedge clk);
            if (resetN) begin
                modelQueue(req, spacer, expResp, expStatus);
                checkError(expStatus.errorCode, status.errorCode);
                checkStatus(expStatus, status);
                if (expStatus.respValid) checkResp(expResp, resp);
            end
        end
    end

    task automatic issue(input prefetchPkg::opcodeT op, input logic [31:0] addr);
        @(posedge clk);
        #2;
        req.opcode = op;
        req.addr   = addr;
        req.data   = $random(seed);
        req.last   = mPtr[1:0] == 2'd3;      // last only on the fourth block of a burst
    endtask

    task automatic repeatCmd(input prefetchPkg::opcodeT op, input int n);
        for (int i = 0; i < n; i++) issue(op, 32'h0);
    endtask

    // the new name takes effect once the previous command has been checked
    task automatic startTest(input string name);
        @(negedge clk);
        #1;
        testName = name;
    endtask

    initial begin
        #((NUM_CMDS * 40 + 100) * CLK_PERIOD);
        reportFailure("timeout: the command sequence did not finish in time");
    end

    initial begin
        int pick;
        resetN = 1'b0;
        req    = '0;
        spacer = '0;
        testName = "reset";
        repeat (2) @(posedge clk);
        #2 resetN = 1'b1;

        startTest("prefetchThenHit");
        issue(prefetchPkg::OP_READ_REQ_PREF, 32'h1000);
        repeatCmd(prefetchPkg::OP_READ_DATA_SLAVE, 4);
        issue(prefetchPkg::OP_NOP, 32'h1000); // addrHit without a command
        issue(prefetchPkg::OP_READ_REQ_MASTER, 32'h1000);
        repeatCmd(prefetchPkg::OP_READ_DATA_PROMISE, 4);

        startTest("masterMiss");
        issue(prefetchPkg::OP_READ_REQ_MASTER, 32'h1040);
        issue(prefetchPkg::OP_READ_DATA_PROMISE, 32'h0); // data not there yet
        repeatCmd(prefetchPkg::OP_READ_DATA_SLAVE, 4);
        repeatCmd(prefetchPkg::OP_READ_DATA_PROMISE, 4);

        startTest("popHead");
        issue(prefetchPkg::OP_READ_REQ_MASTER, 32'h1080);
        repeatCmd(prefetchPkg::OP_READ_DATA_SLAVE, 4);
        repeatCmd(prefetchPkg::OP_READ_DATA_PROMISE, 4);

        startTest("fillUp");
        spacer = 3'd1;
        issue(prefetchPkg::OP_READ_REQ_PREF, 32'h10c0);
        issue(prefetchPkg::OP_READ_REQ_PREF, 32'h1100);
        issue(prefetchPkg::OP_READ_REQ_PREF, 32'h1140);
        issue(prefetchPkg::OP_READ_REQ_PREF, 32'h1180);
        issue(prefetchPkg::OP_READ_REQ_MASTER, 32'h1180);

        startTest("overflowAndInvalid");
        repeatCmd(prefetchPkg::OP_READ_DATA_SLAVE, 13); // last one finds no open block
        for (int op = 5; op < 8; op++) issue(prefetchPkg::opcodeT'(op), 32'h0);
        issue(prefetchPkg::OP_READ_REQ_MASTER, 32'h10c0);
        issue(prefetchPkg::OP_READ_REQ_MASTER, 32'h1100);
        issue(prefetchPkg::OP_READ_REQ_MASTER, 32'h1140);
        repeatCmd(prefetchPkg::OP_READ_DATA_PROMISE, 12);

        startTest("randomMix");
        spacer = 3'd0;
        for (int i = 0; i < NUM_RANDOM; i++) begin
            pick = ($random(seed) & 32'h7fff_ffff) % 10;
            case (pick)
                0:       issue(prefetchPkg::OP_NOP, 32'h0);
                1:       issue(prefetchPkg::OP_READ_REQ_PREF, 32'h2000 + ((i % 6) << 6));
                2, 3:    issue(prefetchPkg::OP_READ_REQ_MASTER, 32'h2000 + ((i % 6) << 6));
                4, 5, 6: issue(prefetchPkg::OP_READ_DATA_SLAVE, 32'h0);
                default: issue(prefetchPkg::OP_READ_DATA_PROMISE, 32'h0);
            endcase
        end
        repeatCmd(prefetchPkg::OP_NOP, 2);
        @(negedge clk);
        #1;

        if (errSeen[1] == 0 || errSeen[2] == 0 || errSeen[3] == 0 || errSeen[4] == 0) begin
            reportFailure("some error code was never produced by the command sequence");
        end else begin
            $display("*** PASSED ***");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* build.f */
prefetchPkg.sv
prefetchTagStore.sv
prefetchDataStore.sv
prefetchQueueCtrl.sv
prefetchQueue.sv
prefetchQueueSva.sv
prefetchQueueTb.sv

/* Bender.yml */
package:
  name: prefetch_queue

sources:
  - prefetchPkg.sv
  - prefetchTagStore.sv
  - prefetchDataStore.sv
  - prefetchQueueCtrl.sv
  - prefetchQueue.sv
  - target: test
    files:
      - prefetchQueueSva.sv
      - prefetchQueueTb.sv
